/* hdl/zx_ports_pkg.sv */
////////////////////////////////////////
// zx port block shared definitions
// port numbers, bus and read-claim types
////////////////////////////////////////

`default_nettype none

package zx_ports_pkg;

	// low-byte port numbers
	localparam logic [7:0] PORT_FE = 8'hFE; // border, keyboard
	localparam logic [7:0] PORT_F6 = 8'hF6; // alias of FE
	localparam logic [7:0] PORT_FD = 8'hFD; // ay and 7ffd
	localparam logic [7:0] PORT_F7 = 8'hF7; // eff7
	localparam logic [7:0] PORT_BF = 8'hBF; // config
	localparam logic [7:0] PORT_BE = 8'hBE; // read-back, nmi end
	localparam logic [7:0] SD_CFG  = 8'h77;
	localparam logic [7:0] SD_DAT  = 8'h57;

	// ide data pair
	localparam logic [7:0] IDE_DAT_LO = 8'h10;
	localparam logic [7:0] IDE_DAT_HI = 8'h11;

	// ide task file
	localparam logic [7:0] IDE_REG_30 = 8'h30;
	localparam logic [7:0] IDE_REG_50 = 8'h50;
	localparam logic [7:0] IDE_REG_70 = 8'h70;
	localparam logic [7:0] IDE_REG_90 = 8'h90;
	localparam logic [7:0] IDE_REG_B0 = 8'hB0;
	localparam logic [7:0] IDE_REG_D0 = 8'hD0;
	localparam logic [7:0] IDE_REG_F0 = 8'hF0;
	localparam logic [7:0] IDE_CTL_C8 = 8'hC8; // on cs1

	// number of read claimants on the data bus
	localparam int NUM_PEERS = 5;

	////////////////////////////////////////
	// bus types

	// z80 bus as every peer sees it
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  din;
		logic        iorq_n;
		logic        rd_n;
		logic        wr_n;
	} z80_bus_t;

	// one-clock io strobes
	typedef struct packed {
		logic wr;
		logic rd;
	} io_strobe_t;

	// what a peer offers for the current IN
	typedef struct packed {
		logic       hit;  // address is ours
		logic [7:0] data;
	} rd_claim_t;

endpackage

`default_nettype wire

/* hdl/io_cycle_detect.sv */
////////////////////////////////////////
// io cycle detector
// iorq with rd/wr to one-clock strobes
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module io_cycle_detect
(
	input  wire                     zclk,
	input  wire                     rst_n,
	input  zx_ports_pkg::z80_bus_t  zbus,
	output zx_ports_pkg::io_strobe_t iostb
);
	logic wr_lvl;  // io write in progress
	logic rd_lvl;  // io read in progress
	logic wr_prev;
	logic rd_prev;

	assign wr_lvl = ~(zbus.iorq_n | zbus.wr_n);
	assign rd_lvl = ~(zbus.iorq_n | zbus.rd_n);

	// strobe on the first sample of each access
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_prev  <= 1'b0;
			rd_prev  <= 1'b0;
			iostb.wr <= 1'b0;
			iostb.rd <= 1'b0;
		end
		else
		begin
			wr_prev  <= wr_lvl;
			rd_prev  <= rd_lvl;
			iostb.wr <= wr_lvl & ~wr_prev; // rising edge only
			iostb.rd <= rd_lvl & ~rd_prev;
		end
	end

endmodule

`default_nettype wire

/* hdl/read_data_arbiter.sv */
////////////////////////////////////////
// read data arbiter
// picks the claiming peer for the z80 bus
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module read_data_arbiter
#(
	parameter int NUM_PEERS = zx_ports_pkg::NUM_PEERS
)
(
	input  zx_ports_pkg::rd_claim_t claims [NUM_PEERS],
	input  zx_ports_pkg::z80_bus_t  zbus,
	output logic [7:0]              dout,
	output logic                    porthit,
	output logic                    dataout
);
	import zx_ports_pkg::*;

	logic ay_data; // FFFD is answered by the ay chip

	// walk from lowest priority so slot 0 ends on top
	always_comb
	begin
		dout    = 8'hFF; // idle bus value
		porthit = 1'b0;
		for (int i = NUM_PEERS - 1; i >= 0; i--)
		begin
			if (claims[i].hit)
			begin
				dout    = claims[i].data;
				porthit = 1'b1;
			end
		end
	end

	assign ay_data = (zbus.addr[7:0] == PORT_FD) && (zbus.addr[15:14] == 2'b11);

	// drive the bus only during our own IN
	assign dataout = porthit & ~zbus.iorq_n & ~zbus.rd_n & ~ay_data;

endmodule

`default_nettype wire

/* hdl/ula_ay_ports.sv */
////////////////////////////////////////
// ula border/keyboard and ay select
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ula_ay_ports
(
	input  wire                      zclk,
	input  wire                      rst_n,
	input  zx_ports_pkg::z80_bus_t   zbus,
	input  zx_ports_pkg::io_strobe_t iostb,
	input  wire  [4:0]               keys_in,
	input  wire                      tape_read,
	output logic [3:0]               border,
	output logic                     ay_bc1,
	output logic                     ay_bdir,
	output zx_ports_pkg::rd_claim_t  claim
);
	import zx_ports_pkg::*;

	logic [7:0] loa;
	logic       fe_sel;  // FE or its F6 alias
	logic       ay_reg;  // FFFD, register select
	logic       ay_dat;  // BFFD, data write

	assign loa    = zbus.addr[7:0];
	assign fe_sel = (loa == PORT_FE) || (loa == PORT_F6);

	// border with bright bit from inverted a3
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			border <= 4'd0;
		else if (fe_sel && iostb.wr)
			border <= {~zbus.addr[3], zbus.din[2:0]};
	end

	////////////////////////////////////////
	// ay chip control

	assign ay_reg = (loa == PORT_FD) && (zbus.addr[15:14] == 2'b11);
	assign ay_dat = (loa == PORT_FD) && (zbus.addr[15:14] == 2'b10);

	// live bus qualified
	assign ay_bc1  = ay_reg & ~zbus.iorq_n & (~zbus.rd_n | ~zbus.wr_n);
	assign ay_bdir = (ay_reg | ay_dat) & ~zbus.iorq_n & ~zbus.wr_n;

	// FD claimed but read back as idle
	assign claim.hit  = fe_sel || (loa == PORT_FD);
	assign claim.data = fe_sel ? {1'b1, tape_read, 1'b0, keys_in} : 8'hFF;

endmodule

`default_nettype wire

/* hdl/mem_paging_regs.sv */
////////////////////////////////////////
// memory paging registers 7ffd and eff7
// 48k lock and 1M page extension
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mem_paging_regs
(
	input  wire                      zclk,
	input  wire                      rst_n,
	input  zx_ports_pkg::z80_bus_t   zbus,
	input  zx_ports_pkg::io_strobe_t iostb,
	input  wire                      shadow,
	output logic [7:0]               p7ffd,
	output logic [7:0]               peff7,
	output logic [7:0]               p7ffd_raw,
	output logic [7:0]               peff7_raw,
	output logic [5:0]               pent1m_page,
	output logic                     pent1m_rom,
	output logic                     pent1m_1m_on,
	output logic                     pent1m_ram0_0,
	output zx_ports_pkg::rd_claim_t  claim
);
	import zx_ports_pkg::*;

	logic [7:0] p7ffd_int;
	logic [7:0] peff7_int;
	logic       block1m;   // eff7.2, back to 128k paging
	logic       block7ffd; // 48k lock
	logic       wr_7ffd;
	logic       wr_eff7;

	assign block1m   = peff7_int[2];
	assign block7ffd = p7ffd_int[5] & block1m;

	assign wr_7ffd = iostb.wr && (zbus.addr[7:0] == PORT_FD) && !zbus.addr[15] && !block7ffd;

	// EFF7 only outside shadow mode
	assign wr_eff7 = iostb.wr && (zbus.addr[7:0] == PORT_F7) && !zbus.addr[12]
		&& zbus.addr[8] && !shadow;

	// 2..0 page, 3 screen, 4 rom, 5 lock, 7..6 high page
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			p7ffd_int <= 8'h00;
		else if (wr_7ffd)
			p7ffd_int <= zbus.din;
	end

	// 0 p16c, 2 block1m, 3 ram0 at 0, 4 turbo off
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			peff7_int <= 8'h00;
		else if (wr_eff7)
			peff7_int <= zbus.din;
	end

	////////////////////////////////////////
	// outputs

	assign p7ffd = {(block1m ? 3'b000 : p7ffd_int[7:5]), p7ffd_int[4:0]};
	assign peff7 = block1m
		? {peff7_int[7], 1'b0, peff7_int[5:4], 3'b000, peff7_int[0]}
		: peff7_int;

	assign p7ffd_raw = p7ffd_int; // unmasked for BE read-back
	assign peff7_raw = peff7_int;

	assign pent1m_page   = {p7ffd_int[7:5], p7ffd_int[2:0]};
	assign pent1m_rom    = p7ffd_int[4];
	assign pent1m_1m_on  = ~peff7_int[2];
	assign pent1m_ram0_0 = peff7_int[3];

	// write only
	assign claim = '{hit: 1'b0, data: 8'hFF};

endmodule

`default_nettype wire

/* hdl/evo_config_port.sv */
////////////////////////////////////////
// evo config port BF and read-back BE
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module evo_config_port
(
	input  wire                      zclk,
	input  wire                      rst_n,
	input  zx_ports_pkg::z80_bus_t   zbus,
	input  zx_ports_pkg::io_strobe_t iostb,
	input  wire                      dos,
	input  wire  [7:0]               p7ffd_raw,
	input  wire  [7:0]               peff7_raw,
	output logic                     shadow,
	output logic                     romrw_en,
	output logic                     set_nmi,
	output logic                     clr_nmi,
	output zx_ports_pkg::rd_claim_t  claim
);
	import zx_ports_pkg::*;

	logic [7:0] loa;
	logic       shadow_en; // BF bit 0
	logic [7:0] be_mux;

	assign loa = zbus.addr[7:0];

	// BF write
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			shadow_en <= 1'b0;
			romrw_en  <= 1'b0;
			set_nmi   <= 1'b0;
		end
		else if ((loa == PORT_BF) && iostb.wr)
		begin
			shadow_en <= zbus.din[0];
			romrw_en  <= zbus.din[1];
			set_nmi   <= zbus.din[3];
		end
	end

	assign shadow  = dos | shadow_en;
	assign clr_nmi = (loa == PORT_BE) && iostb.wr; // nmi handler done

	// BE read-back selected by a11..8
	always_comb
	begin
		case (zbus.addr[11:8])
			4'hA:    be_mux = p7ffd_raw;
			4'hB:    be_mux = peff7_raw;
			default: be_mux = 8'hFF;
		endcase
	end

	assign claim.hit  = (loa == PORT_BF) || (loa == PORT_BE);
	assign claim.data = (loa == PORT_BF)
		? {4'b0000, set_nmi, 1'b0, romrw_en, shadow_en}
		: be_mux;

endmodule

`default_nettype wire

/* hdl/ide_bridge.sv */
////////////////////////////////////////
// ide 8-to-16 bit data bridge
// normal and nemo-divide byte order
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ide_bridge
(
	input  wire                      zclk,
	input  wire                      rst_n,
	input  zx_ports_pkg::z80_bus_t   zbus,
	input  zx_ports_pkg::io_strobe_t iostb,
	input  wire  [15:0]              idein,
	output logic [15:0]              ideout,
	output logic                     idedataout,
	output logic [2:0]               ide_a,
	output logic                     ide_cs0_n,
	output logic                     ide_cs1_n,
	output logic                     ide_rd_n,
	output logic                     ide_wr_n,
	output zx_ports_pkg::rd_claim_t  claim
);
	import zx_ports_pkg::*;

	// normal read  #10 low, #11 high
	// divide read  #10 low, #10 high
	// normal write #11 high, #10 low
	// divide write #10 low, #10 high

	logic [7:0]  loa;
	logic        ide_ports; // ports wired to the drive
	logic        ide_any;   // drive ports plus #11
	logic        lo_sel;
	logic        hi_sel;
	logic        rd_trig;   // divide read, high byte next
	logic        wrlo_trig; // divide write, low byte stored
	logic        wrhi_trig; // normal write, high byte stored
	logic        rd_latch;  // trigger state seen by the cycle
	logic        wrlo_latch;
	logic        wrhi_latch;
	logic [15:0] idewrreg;  // pre-written half
	logic [7:0]  idehiin;   // high half of last drive read

	assign loa    = zbus.addr[7:0];
	assign lo_sel = (loa == IDE_DAT_LO);
	assign hi_sel = (loa == IDE_DAT_HI);

	always_comb
	begin
		case (loa)
			IDE_DAT_LO, IDE_REG_30, IDE_REG_50, IDE_REG_70, IDE_REG_90,
			IDE_REG_B0, IDE_REG_D0, IDE_REG_F0, IDE_CTL_C8:
				ide_ports = 1'b1;
			default:
				ide_ports = 1'b0;
		endcase
	end

	assign ide_any = ide_ports | hi_sel;

	////////////////////////////////////////
	// sequencing triggers

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_trig   <= 1'b0;
			wrlo_trig <= 1'b0;
			wrhi_trig <= 1'b0;
		end
		else if (ide_any && (iostb.rd || iostb.wr))
		begin
			rd_trig   <= lo_sel && iostb.rd && !rd_trig;
			wrhi_trig <= hi_sel && iostb.wr;
			wrlo_trig <= lo_sel && iostb.wr && !wrhi_trig && !wrlo_trig;
		end
	end

	// hold the trigger state through the whole access
	// reloaded only while the bus is idle
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_latch   <= 1'b0;
			wrlo_latch <= 1'b0;
			wrhi_latch <= 1'b0;
		end
		else
		begin
			if (zbus.iorq_n || zbus.rd_n)
				rd_latch <= rd_trig;
			if (zbus.iorq_n || zbus.wr_n)
			begin
				wrlo_latch <= wrlo_trig;
				wrhi_latch <= wrhi_trig;
			end
		end
	end

	// data halves
	always_ff @(posedge zclk)
	begin
		if (iostb.wr && hi_sel)
			idewrreg[15:8] <= zbus.din;
		if (iostb.wr && lo_sel && !wrlo_trig)
			idewrreg[7:0] <= zbus.din;
		if (iostb.rd && lo_sel && !rd_trig)
			idehiin <= idein[15:8]; // kept for the second read
	end

	////////////////////////////////////////
	// drive side

	assign ide_a     = zbus.addr[7:5];
	assign ide_cs0_n = ~ide_ports | (loa == IDE_CTL_C8);
	assign ide_cs1_n = ~ide_ports | (loa != IDE_CTL_C8);

	// no drive read on the divide high-byte #10
	assign ide_rd_n = zbus.iorq_n | zbus.rd_n | ~ide_ports | (rd_latch & lo_sel);

	// #10 writes to the drive only with a stored half
	assign ide_wr_n = zbus.iorq_n | zbus.wr_n | ~ide_ports
		| (lo_sel & ~wrlo_latch & ~wrhi_latch);

	assign idedataout = ide_rd_n;

	assign ideout[15:8] = wrhi_latch ? idewrreg[15:8] : zbus.din;
	assign ideout[7:0]  = wrlo_latch ? idewrreg[7:0] : zbus.din;

	assign claim.hit  = ide_any;
	assign claim.data = (hi_sel || (rd_latch && lo_sel)) ? idehiin : idein[7:0];

endmodule

`default_nettype wire

/* hdl/sd_port.sv */
////////////////////////////////////////
// sd card control and data ports
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sd_port
(
	input  wire                      zclk,
	input  wire                      rst_n,
	input  zx_ports_pkg::z80_bus_t   zbus,
	input  zx_ports_pkg::io_strobe_t iostb,
	input  wire                      shadow,
	input  wire  [7:0]               sd_dataout,
	output logic                     sdcs_n,
	output logic                     sd_start,
	output logic [7:0]               sd_datain,
	output zx_ports_pkg::rd_claim_t  claim
);
	import zx_ports_pkg::*;

	logic [7:0] loa;
	logic       cfg_sel; // 77 normal, 57 with a15 in shadow
	logic       dat_wr;
	logic       dat_rd;

	assign loa = zbus.addr[7:0];

	assign cfg_sel = ((loa == SD_CFG) && !shadow)
		|| ((loa == SD_DAT) && shadow && zbus.addr[15]);

	assign dat_wr = iostb.wr && (loa == SD_DAT) && (!shadow || !zbus.addr[15]);
	assign dat_rd = iostb.rd && (loa == SD_DAT);

	// chip select from din bit 1
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			sdcs_n <= 1'b1;
		else if (cfg_sel && iostb.wr)
			sdcs_n <= zbus.din[1];
	end

	assign sd_start  = dat_wr | dat_rd;                  // spi byte kick
	assign sd_datain = zbus.wr_n ? 8'hFF : zbus.din;     // FF clocks in on reads

	// 77 reads 00, card present and writable
	assign claim.hit  = ((loa == SD_CFG) && !shadow) || (loa == SD_DAT);
	assign claim.data = (loa == SD_DAT) ? sd_dataout : 8'h00;

endmodule

`default_nettype wire

/* hdl/zx_ports_top.sv */
////////////////////////////////////////
// zx port block top level
// z80 bus fan-out to port peers
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module zx_ports_top
(
	input  wire         zclk,
	input  wire         rst_n,
	input  wire  [15:0] a,
	input  wire  [7:0]  din,
	input  wire         iorq_n,
	input  wire         rd_n,
	input  wire         wr_n,
	input  wire         dos,
	input  wire  [4:0]  keys_in,
	input  wire         tape_read,
	input  wire  [15:0] idein,
	input  wire  [7:0]  sd_dataout,
	output logic [7:0]  dout,
	output logic        dataout,
	output logic        porthit,
	output logic [3:0]  border,
	output logic        ay_bc1,
	output logic        ay_bdir,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic [5:0]  pent1m_page,
	output logic        pent1m_rom,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0,
	output logic        romrw_en,
	output logic        set_nmi,
	output logic        clr_nmi,
	output logic [15:0] ideout,
	output logic        idedataout,
	output logic [2:0]  ide_a,
	output logic        ide_cs0_n,
	output logic        ide_cs1_n,
	output logic        ide_rd_n,
	output logic        ide_wr_n,
	output logic        sdcs_n,
	output logic        sd_start,
	output logic [7:0]  sd_datain
);
	import zx_ports_pkg::*;

	z80_bus_t   zbus;
	io_strobe_t iostb;
	rd_claim_t  claims [NUM_PEERS]; // slot 0 wins
	logic       shadow;             // dos or config shadow
	logic [7:0] p7ffd_raw;
	logic [7:0] peff7_raw;

	assign zbus = '{addr: a, din: din, iorq_n: iorq_n, rd_n: rd_n, wr_n: wr_n};

	io_cycle_detect u_cycle
	(
		.zclk  (zclk),
		.rst_n (rst_n),
		.zbus  (zbus),
		.iostb (iostb)
	);

	read_data_arbiter #(.NUM_PEERS(NUM_PEERS)) u_arb
	(
		.claims  (claims),
		.zbus    (zbus),
		.dout    (dout),
		.porthit (porthit),
		.dataout (dataout)
	);

	ula_ay_ports u_ula
	(
		.zclk      (zclk),
		.rst_n     (rst_n),
		.zbus      (zbus),
		.iostb     (iostb),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.border    (border),
		.ay_bc1    (ay_bc1),
		.ay_bdir   (ay_bdir),
		.claim     (claims[0])
	);

	mem_paging_regs u_paging
	(
		.zclk          (zclk),
		.rst_n         (rst_n),
		.zbus          (zbus),
		.iostb         (iostb),
		.shadow        (shadow),
		.p7ffd         (p7ffd),
		.peff7         (peff7),
		.p7ffd_raw     (p7ffd_raw),
		.peff7_raw     (peff7_raw),
		.pent1m_page   (pent1m_page),
		.pent1m_rom    (pent1m_rom),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0),
		.claim         (claims[1])
	);

	evo_config_port u_config
	(
		.zclk      (zclk),
		.rst_n     (rst_n),
		.zbus      (zbus),
		.iostb     (iostb),
		.dos       (dos),
		.p7ffd_raw (p7ffd_raw),
		.peff7_raw (peff7_raw),
		.shadow    (shadow),
		.romrw_en  (romrw_en),
		.set_nmi   (set_nmi),
		.clr_nmi   (clr_nmi),
		.claim     (claims[2])
	);

	ide_bridge u_ide
	(
		.zclk       (zclk),
		.rst_n      (rst_n),
		.zbus       (zbus),
		.iostb      (iostb),
		.idein      (idein),
		.ideout     (ideout),
		.idedataout (idedataout),
		.ide_a      (ide_a),
		.ide_cs0_n  (ide_cs0_n),
		.ide_cs1_n  (ide_cs1_n),
		.ide_rd_n   (ide_rd_n),
		.ide_wr_n   (ide_wr_n),
		.claim      (claims[3])
	);

	sd_port u_sd
	(
		.zclk       (zclk),
		.rst_n      (rst_n),
		.zbus       (zbus),
		.iostb      (iostb),
		.shadow     (shadow),
		.sd_dataout (sd_dataout),
		.sdcs_n     (sdcs_n),
		.sd_start   (sd_start),
		.sd_datain  (sd_datain),
		.claim      (claims[4])
	);

endmodule

`default_nettype wire

/* verification/zx_ports_checker.sv */
////////////////////////////////////////
// zx port block checker
// port register model and bus compare
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module zx_ports_checker
(
	input  wire         zclk,
	input  wire         rst_n,
	input  wire  [15:0] a,
	input  wire  [7:0]  din,
	input  wire         iorq_n,
	input  wire         rd_n,
	input  wire         wr_n,
	input  wire         dos,
	input  wire  [4:0]  keys_in,
	input  wire         tape_read,
	input  wire  [15:0] idein,
	input  wire  [7:0]  sd_dataout,
	input  wire  [7:0]  dout,
	input  wire         dataout,
	input  wire         porthit,
	input  wire  [3:0]  border,
	input  wire         ay_bc1,
	input  wire         ay_bdir,
	input  wire  [7:0]  p7ffd,
	input  wire  [7:0]  peff7,
	input  wire  [5:0]  pent1m_page,
	input  wire         pent1m_rom,
	input  wire         pent1m_1m_on,
	input  wire         pent1m_ram0_0,
	input  wire         romrw_en,
	input  wire         set_nmi,
	input  wire         clr_nmi,
	input  wire  [15:0] ideout,
	input  wire         idedataout,
	input  wire  [2:0]  ide_a,
	input  wire         ide_cs0_n,
	input  wire         ide_cs1_n,
	input  wire         ide_rd_n,
	input  wire         ide_wr_n,
	input  wire         sdcs_n,
	input  wire         sd_start,
	input  wire  [7:0]  sd_datain,
	input  wire  [3:0]  phase,   // test group from the tb
	output int          errors,
	output int          checked  // accesses fully compared
);
	import zx_ports_pkg::*;

	// port register model
	logic [3:0]  m_border;
	logic [7:0]  m_7ffd;
	logic [7:0]  m_eff7;
	logic        m_shen;      // config shadow enable
	logic        m_romrw;
	logic        m_nmi;
	logic        m_sdcs;
	logic        ide_rdpend;  // high byte due on next #10 read
	logic        ide_wrhi;    // high byte stored by #11 write
	logic [7:0]  ide_hi;      // stored high half of a drive read
	logic [7:0]  ide_whi;     // stored high half for a drive write
	logic        shadow;

	// current access
	logic        in_acc;
	logic        acc_wr;
	logic [15:0] acc_addr;
	logic [7:0]  acc_din;
	int          sd_cnt;      // sd_start pulses seen
	int          nmi_cnt;     // clr_nmi pulses seen

	assign shadow = dos | m_shen;

	initial
	begin
		errors  = 0;
		checked = 0;
	end

	function automatic string test_name(input logic [3:0] p);
		case (p)
			4'd0:    test_name = "reset";
			4'd1:    test_name = "border";
			4'd2:    test_name = "paging";
			4'd3:    test_name = "config";
			4'd4:    test_name = "ide";
			4'd5:    test_name = "sd_ay";
			default: test_name = "unclaimed";
		endcase
	endfunction

	function automatic logic is_ide(input logic [7:0] lo);
		case (lo)
			IDE_DAT_LO, IDE_DAT_HI, IDE_REG_30, IDE_REG_50, IDE_REG_70,
			IDE_REG_90, IDE_REG_B0, IDE_REG_D0, IDE_REG_F0, IDE_CTL_C8:
				is_ide = 1'b1;
			default:
				is_ide = 1'b0;
		endcase
	endfunction

	////////////////////////////////////////
	// reference read as {hit, data}

	function automatic logic [8:0] exp_read(input logic [15:0] ad);
		logic [7:0] lo;
		lo = ad[7:0];
		case (lo)
			PORT_FE, PORT_F6: exp_read = {1'b1, 1'b1, tape_read, 1'b0, keys_in};
			PORT_FD:          exp_read = {1'b1, 8'hFF};  // ay answers itself
			PORT_BF:          exp_read = {1'b1, 4'h0, m_nmi, 1'b0, m_romrw, m_shen};
			PORT_BE:
				exp_read = {1'b1, (ad[11:8] == 4'hA) ? m_7ffd
					: ((ad[11:8] == 4'hB) ? m_eff7 : 8'hFF)};
			IDE_DAT_LO:       exp_read = {1'b1, ide_rdpend ? ide_hi : idein[7:0]};
			IDE_DAT_HI:       exp_read = {1'b1, ide_hi};
			SD_CFG:           exp_read = shadow ? 9'h0FF : 9'h100;
			SD_DAT:           exp_read = {1'b1, sd_dataout};
			default:          exp_read = is_ide(lo) ? {1'b1, idein[7:0]} : 9'h0FF;
		endcase
	endfunction

	task automatic compare(input string what, input logic [15:0] expv, input logic [15:0] actv);
		if (expv !== actv)
		begin
			errors++;
			$display("ERR %s %s: expected %h actual %h", test_name(phase), what, expv, actv);
		end
	endtask

	// live bus outputs at the first sample of the access
	task automatic check_live;
		logic [8:0] er;
		logic [7:0] lo;
		logic       drv;     // port wired to the drive
		logic       rd_exp;  // expected ide_rd_n
		lo     = acc_addr[7:0];
		drv    = is_ide(lo) && (lo != IDE_DAT_HI);
		rd_exp = acc_wr || !drv || ((lo == IDE_DAT_LO) && ide_rdpend);
		compare("ide_a", acc_addr[7:5], ide_a);
		compare("ide_cs0_n", !drv || (lo == IDE_CTL_C8), ide_cs0_n);
		compare("ide_cs1_n", lo != IDE_CTL_C8, ide_cs1_n);
		compare("ide_rd_n", rd_exp, ide_rd_n);
		compare("idedataout", rd_exp, idedataout);  // bus to the drive unless reading it
		compare("sd_datain", acc_wr ? acc_din : 8'hFF, sd_datain);
		compare("ay_bc1", (lo == PORT_FD) && (acc_addr[15:14] == 2'b11), ay_bc1);
		compare("ay_bdir", acc_wr && (lo == PORT_FD) && acc_addr[15], ay_bdir);
		if (!acc_wr || !drv)
			compare("ide_wr_n", 1'b1, ide_wr_n);  // no drive write
		else if ((lo == IDE_DAT_LO) && ide_wrhi)
		begin
			compare("ide_wr_n", 1'b0, ide_wr_n);
			compare("ideout", {ide_whi, acc_din}, ideout);
		end
		if (!acc_wr)
		begin
			er = exp_read(acc_addr);
			compare("porthit", er[8], porthit);
			compare("dout", er[7:0], dout);
			compare("dataout", er[8] && !((lo == PORT_FD) && (acc_addr[15:14] == 2'b11)),
				dataout);
		end
	endtask

	task automatic update_model;
		logic [7:0] lo;
		lo = acc_addr[7:0];
		if (acc_wr)
		begin
			if ((lo == PORT_FE) || (lo == PORT_F6))
				m_border = {~acc_addr[3], acc_din[2:0]};
			if ((lo == PORT_FD) && !acc_addr[15] && !(m_7ffd[5] && m_eff7[2]))
				m_7ffd = acc_din;  // unless 48k locked
			if ((lo == PORT_F7) && !acc_addr[12] && acc_addr[8] && !shadow)
				m_eff7 = acc_din;
			if (lo == PORT_BF)
			begin
				m_shen  = acc_din[0];
				m_romrw = acc_din[1];
				m_nmi   = acc_din[3];
			end
			if (((lo == SD_CFG) && !shadow) || ((lo == SD_DAT) && shadow && acc_addr[15]))
				m_sdcs = acc_din[1];
		end
		else if ((lo == IDE_DAT_LO) && !ide_rdpend)
			ide_hi = idein[15:8];
		if (is_ide(lo))
		begin
			ide_rdpend = (lo == IDE_DAT_LO) && !acc_wr && !ide_rdpend;
			if (acc_wr && (lo == IDE_DAT_HI))
				ide_whi = acc_din;
			ide_wrhi = (lo == IDE_DAT_HI) && acc_wr;
		end
	endtask

	// registers and pulse counts once the bus is idle again
	task automatic check_after;
		logic [7:0] lo;
		logic       blk;
		lo  = acc_addr[7:0];
		blk = m_eff7[2];  // 128k paging mode
		compare("border", m_border, border);
		compare("p7ffd", blk ? {3'b000, m_7ffd[4:0]} : m_7ffd, p7ffd);
		compare("peff7", blk ? (m_eff7 & 8'hB1) : m_eff7, peff7);
		compare("pent1m_page", {m_7ffd[7:5], m_7ffd[2:0]}, pent1m_page);
		compare("pent1m_rom", m_7ffd[4], pent1m_rom);
		compare("pent1m_1m_on", !m_eff7[2], pent1m_1m_on);
		compare("pent1m_ram0_0", m_eff7[3], pent1m_ram0_0);
		compare("romrw_en", m_romrw, romrw_en);
		compare("set_nmi", m_nmi, set_nmi);
		compare("sdcs_n", m_sdcs, sdcs_n);
		compare("sd_start pulses",
			((lo == SD_DAT) && !(acc_wr && shadow && acc_addr[15])) ? 16'd1 : 16'd0, sd_cnt);
		compare("clr_nmi pulses", (acc_wr && (lo == PORT_BE)) ? 16'd1 : 16'd0, nmi_cnt);
	endtask

	////////////////////////////////////////
	// comparing process on the stable negedge

	always @(negedge zclk)
	begin
		if (!rst_n)
		begin
			m_border   = 4'd0;
			m_7ffd     = 8'h00;
			m_eff7     = 8'h00;
			m_shen     = 1'b0;
			m_romrw    = 1'b0;
			m_nmi      = 1'b0;
			m_sdcs     = 1'b1;
			ide_rdpend = 1'b0;
			ide_wrhi   = 1'b0;
			in_acc     = 1'b0;
		end
		else if (!iorq_n && !(rd_n && wr_n))
		begin
			if (!in_acc)
			begin
				in_acc   = 1'b1;
				acc_addr = a;
				acc_din  = din;
				acc_wr   = !wr_n;
				sd_cnt   = 0;
				nmi_cnt  = 0;
				check_live;
				update_model;
			end
		end
		else if (in_acc)
		begin
			in_acc = 1'b0;
			check_after;
			checked++;
		end
	end

	// strobe pulses counted mid-cycle
	always @(negedge zclk)
	begin
		if (sd_start)
			sd_cnt++;
		if (clr_nmi)
			nmi_cnt++;
	end

endmodule

`default_nettype wire

/* verification/zx_ports_tb.sv */
////////////////////////////////////////
// zx port block testbench
// z80 io cycles through every port group
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module zx_ports_tb;
	import zx_ports_pkg::*;

	// dut inputs
	logic        zclk;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [15:0] idein;
	logic [7:0]  sd_dataout;

	// dut outputs
	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	logic [3:0]  border;
	logic        ay_bc1;
	logic        ay_bdir;
	logic [7:0]  p7ffd;
	logic [7:0]  peff7;
	logic [5:0]  pent1m_page;
	logic        pent1m_rom;
	logic        pent1m_1m_on;
	logic        pent1m_ram0_0;
	logic        romrw_en;
	logic        set_nmi;
	logic        clr_nmi;
	logic [15:0] ideout;
	logic        idedataout;
	logic [2:0]  ide_a;
	logic        ide_cs0_n;
	logic        ide_cs1_n;
	logic        ide_rd_n;
	logic        ide_wr_n;
	logic        sdcs_n;
	logic        sd_start;
	logic [7:0]  sd_datain;

	logic [3:0]  phase;      // test group for the checker
	int          chk_errors;
	int          chk_count;
	int          timeouts;
	int          seed;
	int          rnd;
	logic [7:0]  page_val;   // 7ffd value that arms the lock

	zx_ports_top DUT (.*);

	zx_ports_checker u_chk (.*, .errors(chk_errors), .checked(chk_count));

	initial
	begin
		zclk = 1'b0;
		forever
			#50 zclk = ~zclk;
	end

	function automatic logic [7:0] rand8();
		rand8 = $urandom;
	endfunction

	////////////////////////////////////////
	// z80 io cycles

	// hold one access 3 clocks and wait for the checker
	task automatic run_access(input logic [15:0] addr, input logic [7:0] data, input logic is_wr);
		int want;
		int n;
		want = chk_count + 1;
		@(posedge zclk);
		#5;
		a      = addr;
		din    = data;
		iorq_n = 1'b0;
		if (is_wr)
			wr_n = 1'b0;
		else
			rd_n = 1'b0;
		repeat (3) @(posedge zclk);
		#5;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		n = 0;
		while ((chk_count < want) && (n < 20))
		begin
			@(posedge zclk);
			n++;
		end
		if (chk_count < want)
		begin
			timeouts++;
			$display("timeout: checker never finished the access to port %h", addr);
		end
		#5;  // next input changes off the edge
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		run_access(addr, data, 1'b1);
	endtask

	task automatic io_read(input logic [15:0] addr);
		run_access(addr, din, 1'b0);
	endtask

	////////////////////////////////////////
	// stimulus

	initial
	begin
		rst_n      = 1'b0;
		a          = 16'h0000;
		din        = 8'h00;
		iorq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		dos        = 1'b0;
		keys_in    = 5'h1F;
		tape_read  = 1'b0;
		idein      = 16'h0000;
		sd_dataout = 8'h00;
		phase      = 4'd0;
		timeouts   = 0;
		page_val   = 8'h00;
		seed       = 32;
		rnd        = $urandom(seed);  // one seed for the run

		repeat (2) @(posedge zclk);
		#5;
		rst_n = 1'b1;

		io_read(16'h3F00);  // reset values through an unclaimed port

		phase = 4'd1;
		for (int i = 0; i < 4; i++)
		begin
			io_write({rand8(), (i % 2) ? PORT_F6 : PORT_FE}, rand8());
			keys_in   = $urandom;
			tape_read = $urandom;
			io_read({rand8(), PORT_FE});
		end

		phase = 4'd2;
		io_write(16'h7FFD, rand8());
		io_write(16'h7FFD, rand8());
		io_write(16'hEFF7, rand8() | 8'h4E);  // 128k paging with the masked bits set
		page_val = rand8() | 8'h20;
		io_write(16'h7FFD, page_val);         // arms the 48k lock
		io_write(16'h7FFD, ~page_val);        // locked so ignored

		phase = 4'd3;
		io_write({8'h00, PORT_BF}, (rand8() & 8'hF4) | 8'h0A);
		io_read({8'h00, PORT_BF});
		io_read({8'h0A, PORT_BE});
		io_read({8'h0B, PORT_BE});
		io_read({8'h05, PORT_BE});
		io_write({8'h00, PORT_BE}, rand8());  // nmi done

		phase = 4'd4;
		io_write({8'h00, IDE_DAT_HI}, rand8());
		io_write({8'h00, IDE_DAT_LO}, rand8());
		idein = {rand8(), rand8()};
		io_read({8'h00, IDE_DAT_LO});
		io_read({8'h00, IDE_DAT_HI});
		io_read({8'h00, IDE_CTL_C8});
		io_read({8'h00, IDE_REG_30});

		phase = 4'd5;
		io_write({8'h00, SD_CFG}, rand8() & 8'hFD);  // select the card
		io_write({8'h00, SD_CFG}, rand8() | 8'h02);
		io_write({8'h00, SD_DAT}, rand8());
		sd_dataout = rand8();
		io_read({8'h00, SD_DAT});
		io_write(16'hFFFD, rand8());
		io_write(16'hBFFD, rand8());
		io_read(16'hFFFD);

		phase = 4'd6;
		io_read(16'h00A3);
		io_read(16'h1234);

		repeat (2) @(posedge zclk);
		$display("errors: %0d mismatches, %0d timeouts", chk_errors, timeouts);
		if ((chk_errors == 0) && (timeouts == 0))
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
hdl/zx_ports_pkg.sv
hdl/io_cycle_detect.sv
hdl/read_data_arbiter.sv
hdl/ula_ay_ports.sv
hdl/mem_paging_regs.sv
hdl/evo_config_port.sv
hdl/ide_bridge.sv
hdl/sd_port.sv
hdl/zx_ports_top.sv
verification/zx_ports_checker.sv
verification/zx_ports_tb.sv
